// ==== hw/scroll_pkg.sv ====
// shared widths, limits, bus structs and FSM encodings for the scroll layer blocks
package scroll_pkg;

    localparam int SCREEN_W         = 320;
    localparam int MAP_COLS_SCANNED = 21;   // 20 visible columns plus the partial one
    localparam int NUM_PRI          = 16;
    localparam int MAX_TILE         = 17'h1FFFF;
    localparam int TILE_PX          = 16;
    localparam int SLICE_PX         = 8;
    localparam int QUEUE_DEPTH      = NUM_PRI * MAP_COLS_SCANNED;
    localparam int BUF_DEPTH        = 512;

    typedef logic signed [12:0] scroll_t;
    typedef logic [8:0]         line_t;
    typedef logic [12:0]        map_addr_t;
    typedef logic [15:0]        map_word_t;
    typedef logic [3:0]         pri_t;
    typedef logic [8:0]         q_addr_t;
    typedef logic [4:0]         q_count_t;
    typedef logic [14:0]        pixel_t;    // {priority, palette[6:0], code[3:0]}
    typedef logic [31:0]        gfx_data_t; // pixel n in bits 4n+3:4n

    typedef struct packed {
        map_word_t          num;
        map_word_t          attr;
        logic signed [15:0] xpos;
    } queue_entry_t;

    typedef struct packed {
        logic         valid;
        pri_t         pri;
        queue_entry_t entry;
    } queue_wr_t;

    typedef struct packed {
        logic [12:0] code;
        logic [2:0]  bank;
        logic [3:0]  row;
        logic        slice;   // 0 left half, 1 right half
    } gfx_req_t;

    typedef struct packed {
        logic   valid;
        line_t  x;
        pixel_t pixel;
    } buf_wr_t;

    typedef enum logic [2:0] {
        SC_IDLE, SC_ADDR_NUM, SC_ADDR_ATTR, SC_READ_NUM, SC_READ_ATTR, SC_DONE
    } scan_state_t;

    typedef enum logic [2:0] {
        RN_IDLE, RN_SELECT, RN_READ_Q, RN_FETCH, RN_DRAW, RN_NEXT
    } render_state_t;

endpackage

// ==== hw/scroll_tilemap_scan.sv ====
// walks the 21 tilemap columns of a scanline and pushes the non-blank tiles into the queue
`timescale 1ns/10ps

module scroll_tilemap_scan
    import scroll_pkg::*;
(
    input  logic      CLK96,
    input  logic      RESET96,
    input  logic      hblank_i,
    input  line_t     vrender_i,
    input  scroll_t   scroll_x_i,
    input  scroll_t   scroll_y_i,
    output map_addr_t map_addr_o,
    input  map_word_t map_data_i,
    input  logic      render_busy_i,
    output logic      clear_o,
    output queue_wr_t queue_wr_o,
    output logic      render_start_o,
    output line_t     line_o
);

    scan_state_t        state;
    logic               hblank_q;
    logic               line_fall;
    logic               pending;   // line start seen, waiting for the renderer
    logic               go;
    logic [4:0]         col_k;
    logic               last_col;
    logic [9:0]         fine_y;
    logic [4:0]         tile_row;
    logic [4:0]         tile_col;
    logic               tile_ok;
    logic signed [15:0] tile_xpos;
    map_word_t          tile_num_q;

    assign line_fall = hblank_q & ~hblank_i;
    assign go        = (state == SC_IDLE) && pending && !render_busy_i;
    assign last_col  = (col_k == 5'(MAP_COLS_SCANNED - 1));

    // coarse row plus the carry out of the fine offset, wraps at 32
    assign fine_y   = {1'b0, line_o} + 10'(scroll_y_i[3:0]);
    assign tile_row = scroll_y_i[8:4] + fine_y[8:4];
    assign tile_col = scroll_x_i[8:4] + col_k;

    assign tile_ok   = (map_data_i != '0) && (32'(map_data_i) <= MAX_TILE);
    assign tile_xpos = 16'(col_k) * 16'(TILE_PX) - 16'(scroll_x_i[3:0]);

    assign clear_o        = go;   // wipe the bins before the first push
    assign render_start_o = (state == SC_DONE);

    // attribute word is on map_data_i in READ_ATTR
    assign queue_wr_o.valid      = (state == SC_READ_ATTR);
    assign queue_wr_o.pri        = map_data_i[11:8];
    assign queue_wr_o.entry.num  = tile_num_q;
    assign queue_wr_o.entry.attr = map_data_i;
    assign queue_wr_o.entry.xpos = tile_xpos;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state      <= SC_IDLE;
            hblank_q   <= 1'b0;
            pending    <= 1'b0;
            col_k      <= '0;
            line_o     <= '0;
            map_addr_o <= '0;
        end else begin
            hblank_q <= hblank_i;
            // line number switches on the first clock of the line, read bank follows it
            if (line_fall) begin
                pending <= 1'b1;
                line_o  <= vrender_i;
            end else if (go) begin
                pending <= 1'b0;
            end

            case (state)
                SC_IDLE: begin
                    if (go) begin
                        col_k <= '0;
                        state <= SC_ADDR_NUM;
                    end
                end
                SC_ADDR_NUM: begin
                    map_addr_o <= {2'b00, tile_row, tile_col, 1'b1};   // tile number word
                    state      <= SC_ADDR_ATTR;
                end
                SC_ADDR_ATTR: begin
                    map_addr_o <= {2'b00, tile_row, tile_col, 1'b0};
                    state      <= SC_READ_NUM;
                end
                SC_READ_NUM: begin
                    if (tile_ok) begin
                        state <= SC_READ_ATTR;
                    end else if (last_col) begin
                        state <= SC_DONE;
                    end else begin
                        col_k <= col_k + 1'b1;   // blank tile, 3 cycles
                        state <= SC_ADDR_NUM;
                    end
                end
                SC_READ_ATTR: begin
                    if (last_col) begin
                        state <= SC_DONE;
                    end else begin
                        col_k <= col_k + 1'b1;
                        state <= SC_ADDR_NUM;
                    end
                end
                default: state <= SC_IDLE;   // SC_DONE
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == SC_READ_NUM) begin
            tile_num_q <= map_data_i;
        end
    end

endmodule

// ==== hw/scroll_priority_queue.sv ====
// per-priority tile bins for one scanline; exposes the lowest occupied priority to the renderer
`timescale 1ns/10ps

module scroll_priority_queue
    import scroll_pkg::*;
(
    input  logic         CLK96,
    input  logic         RESET96,
    input  logic         clear_i,
    input  queue_wr_t    wr_i,
    input  pri_t         rd_pri_i,
    input  q_count_t     rd_idx_i,
    output queue_entry_t rd_entry_o,
    input  logic         level_done_i,
    output pri_t         next_pri_o,
    output q_count_t     next_cnt_o,
    output logic         any_o
);

    queue_entry_t              mem [QUEUE_DEPTH];
    q_count_t [NUM_PRI-1:0]    cnt;
    logic [NUM_PRI-1:0]        occ;   // priority still has tiles to draw
    q_addr_t                   wr_addr;
    q_addr_t                   rd_addr;

    // each priority owns a run of 21 slots
    function automatic q_addr_t bin_addr(input pri_t p, input q_count_t i);
        return q_addr_t'(p) * q_addr_t'(MAP_COLS_SCANNED) + q_addr_t'(i);
    endfunction

    assign wr_addr = bin_addr(wr_i.pri, cnt[wr_i.pri]);
    assign rd_addr = bin_addr(rd_pri_i, rd_idx_i);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            cnt <= '0;
            occ <= '0;
        end else if (clear_i) begin
            cnt <= '0;
            occ <= '0;
        end else begin
            if (wr_i.valid) begin
                cnt[wr_i.pri] <= cnt[wr_i.pri] + 1'b1;
                occ[wr_i.pri] <= 1'b1;
            end
            if (level_done_i) begin
                occ[next_pri_o] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (wr_i.valid) begin
            mem[wr_addr] <= wr_i.entry;
        end
        rd_entry_o <= mem[rd_addr];   // one cycle read
    end

    // lowest set bit wins
    always_comb begin
        next_pri_o = '0;
        for (int p = NUM_PRI - 1; p >= 0; p--) begin
            if (occ[p]) begin
                next_pri_o = pri_t'(p);
            end
        end
    end

    assign next_cnt_o = cnt[next_pri_o];
    assign any_o      = |occ;

endmodule

// ==== hw/scroll_tile_render.sv ====
// drains the queue lowest priority first, fetches tile slices and writes opaque pixels to the line buffer
`timescale 1ns/10ps

module scroll_tile_render
    import scroll_pkg::*;
(
    input  logic         CLK96,
    input  logic         RESET96,
    input  logic         start_i,
    input  line_t        line_i,
    input  scroll_t      scroll_y_i,
    input  pri_t         next_pri_i,
    input  q_count_t     next_cnt_i,
    input  logic         any_i,
    output pri_t         rd_pri_o,
    output q_count_t     rd_idx_o,
    input  queue_entry_t rd_entry_i,
    output logic         level_done_o,
    output logic         gfx_cs_o,
    output gfx_req_t     gfx_req_o,
    input  logic         gfx_ok_i,
    input  gfx_data_t    gfx_data_i,
    output buf_wr_t      buf_wr_o,
    output logic         busy_o
);

    render_state_t      state;
    line_t              line_q;
    pri_t               pri_q;
    q_count_t           cnt_q;
    q_count_t           idx_q;
    logic               slice_q;
    logic [2:0]         px_q;
    gfx_data_t          slice_data;
    logic               last_entry;
    logic signed [15:0] px_xpos;
    logic [3:0]         px_code;
    logic               px_visible;
    logic               wr_valid_q;
    line_t              wr_x_q;
    pixel_t             wr_pixel_q;

    assign rd_pri_o     = pri_q;
    assign rd_idx_o     = idx_q;
    assign last_entry   = (q_count_t'(idx_q + 1'b1) == cnt_q);
    assign level_done_o = (state == RN_NEXT) && last_entry;

    // rd_entry_i holds while the queue address is unchanged
    assign px_xpos    = rd_entry_i.xpos + 16'(slice_q) * 16'(SLICE_PX) + 16'(px_q);
    assign px_code    = slice_data[{px_q, 2'b00} +: 4];
    assign px_visible = (px_code != 4'h0) && (px_xpos >= 0) && (px_xpos < SCREEN_W);

    assign buf_wr_o.valid = wr_valid_q;
    assign buf_wr_o.x     = wr_x_q;
    assign buf_wr_o.pixel = wr_pixel_q;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state      <= RN_IDLE;
            busy_o     <= 1'b0;
            gfx_cs_o   <= 1'b0;
            pri_q      <= '0;
            cnt_q      <= '0;
            idx_q      <= '0;
            slice_q    <= 1'b0;
            px_q       <= '0;
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= (state == RN_DRAW) && px_visible;
            case (state)
                RN_IDLE: begin
                    if (start_i) begin
                        busy_o <= 1'b1;
                        state  <= RN_SELECT;
                    end
                end
                RN_SELECT: begin
                    if (any_i) begin
                        pri_q <= next_pri_i;
                        cnt_q <= next_cnt_i;
                        idx_q <= '0;
                        state <= RN_READ_Q;
                    end else begin
                        busy_o <= 1'b0;   // queue empty, line finished
                        state  <= RN_IDLE;
                    end
                end
                RN_READ_Q: begin
                    slice_q <= 1'b0;
                    state   <= RN_FETCH;
                end
                RN_FETCH: begin
                    if (!gfx_cs_o) begin
                        gfx_cs_o <= 1'b1;
                    end else if (gfx_ok_i) begin
                        gfx_cs_o <= 1'b0;
                        px_q     <= '0;
                        state    <= RN_DRAW;
                    end
                end
                RN_DRAW: begin
                    px_q <= px_q + 1'b1;
                    if (px_q == 3'(SLICE_PX - 1)) begin
                        if (slice_q) begin
                            state <= RN_NEXT;
                        end else begin
                            slice_q <= 1'b1;   // right half next
                            state   <= RN_FETCH;
                        end
                    end
                end
                default: begin   // RN_NEXT
                    if (last_entry) begin
                        state <= RN_SELECT;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                        state <= RN_READ_Q;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == RN_IDLE && start_i) begin
            line_q <= line_i;
        end
        // request is built once, held until ok
        if (state == RN_FETCH && !gfx_cs_o) begin
            gfx_req_o <= '{code:  rd_entry_i.num[12:0],
                           bank:  rd_entry_i.num[15:13],
                           row:   4'(line_q[3:0] + scroll_y_i[3:0]),
                           slice: slice_q};
        end
        if (state == RN_FETCH && gfx_cs_o && gfx_ok_i) begin
            slice_data <= gfx_data_i;
        end
        wr_x_q     <= px_xpos[8:0];
        wr_pixel_q <= {pri_q, rd_entry_i.attr[6:0], px_code};
    end

endmodule

// ==== hw/scroll_line_buffer.sv ====
// double line buffer; renderer fills one bank while the other is shown and cleared behind the beam
`timescale 1ns/10ps

module scroll_line_buffer
    import scroll_pkg::*;
(
    input  logic    CLK96,
    input  logic    RESET96,
    input  logic    bank_i,
    input  buf_wr_t wr_i,
    input  line_t   h_i,
    input  logic    rd_en_i,
    output pixel_t  pixel_o
);

    pixel_t mem [2][BUF_DEPTH];
    logic   rd_bank;

    assign rd_bank = ~bank_i;   // display the bank finished last line

    always_ff @(posedge CLK96) begin
        if (wr_i.valid) begin
            mem[bank_i][wr_i.x] <= wr_i.pixel;
        end
        if (rd_en_i) begin
            mem[rd_bank][h_i] <= '0;   // leave it blank for the next render
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            pixel_o <= '0;
        end else if (rd_en_i) begin
            pixel_o <= mem[rd_bank][h_i];
        end
    end

endmodule

// ==== hw/scroll_layer.sv ====
// top of the scroll layer: connects tilemap scan, priority queue, tile renderer and line buffer
`timescale 1ns/10ps

module scroll_layer
    import scroll_pkg::*;
(
    input  logic      CLK96,
    input  logic      RESET96,
    input  logic      pixel_cen_i,
    input  logic      active_i,
    input  logic      hblank_i,
    input  line_t     h_i,
    input  line_t     vrender_i,
    input  scroll_t   scroll_x_i,
    input  scroll_t   scroll_y_i,
    output map_addr_t map_addr_o,
    input  map_word_t map_data_i,
    output logic      gfx_cs_o,
    output gfx_req_t  gfx_req_o,
    input  logic      gfx_ok_i,
    input  gfx_data_t gfx_data_i,
    output pixel_t    pixel_o
);

    queue_wr_t    queue_wr;
    logic         scan_clear;
    logic         render_start;
    logic         render_busy;
    line_t        scan_line;
    pri_t         rd_pri;
    q_count_t     rd_idx;
    queue_entry_t rd_entry;
    logic         level_done;
    pri_t         next_pri;
    q_count_t     next_cnt;
    logic         pri_any;
    buf_wr_t      buf_wr;

    scroll_tilemap_scan scroll_tilemap_scan_inst (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .hblank_i       (hblank_i),
        .vrender_i      (vrender_i),
        .scroll_x_i     (scroll_x_i),
        .scroll_y_i     (scroll_y_i),
        .map_addr_o     (map_addr_o),
        .map_data_i     (map_data_i),
        .render_busy_i  (render_busy),
        .clear_o        (scan_clear),
        .queue_wr_o     (queue_wr),
        .render_start_o (render_start),
        .line_o         (scan_line)
    );

    scroll_priority_queue scroll_priority_queue_inst (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .clear_i      (scan_clear),
        .wr_i         (queue_wr),
        .rd_pri_i     (rd_pri),
        .rd_idx_i     (rd_idx),
        .rd_entry_o   (rd_entry),
        .level_done_i (level_done),
        .next_pri_o   (next_pri),
        .next_cnt_o   (next_cnt),
        .any_o        (pri_any)
    );

    scroll_tile_render scroll_tile_render_inst (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .start_i      (render_start),
        .line_i       (scan_line),
        .scroll_y_i   (scroll_y_i),
        .next_pri_i   (next_pri),
        .next_cnt_i   (next_cnt),
        .any_i        (pri_any),
        .rd_pri_o     (rd_pri),
        .rd_idx_o     (rd_idx),
        .rd_entry_i   (rd_entry),
        .level_done_o (level_done),
        .gfx_cs_o     (gfx_cs_o),
        .gfx_req_o    (gfx_req_o),
        .gfx_ok_i     (gfx_ok_i),
        .gfx_data_i   (gfx_data_i),
        .buf_wr_o     (buf_wr),
        .busy_o       (render_busy)
    );

    // even lines render into bank 0, odd lines into bank 1
    scroll_line_buffer scroll_line_buffer_inst (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .bank_i  (scan_line[0]),
        .wr_i    (buf_wr),
        .h_i     (h_i),
        .rd_en_i (pixel_cen_i & active_i),
        .pixel_o (pixel_o)
    );

endmodule

// ==== testbench/scroll_layer_chk.sv ====
// bound into the tile renderer; checks the ROM handshake and the line buffer writes
`timescale 1ns/10ps

module scroll_layer_chk
    import scroll_pkg::*;
(
    input logic     CLK96,
    input logic     RESET96,
    input logic     gfx_cs_i,
    input gfx_req_t gfx_req_i,
    input logic     gfx_ok_i,
    input buf_wr_t  buf_wr_i
);

    // request frozen while the ROM works on it
    cs_held: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_i && !gfx_ok_i |=> gfx_cs_i && $stable(gfx_req_i))
        else $error("graphics request dropped or changed before gfx_ok");

    cs_release: assert property (@(posedge CLK96) disable iff (RESET96)
        gfx_cs_i && gfx_ok_i |=> !gfx_cs_i)   // one slice per request
        else $error("gfx_cs still high after gfx_ok");

    wr_in_screen: assert property (@(posedge CLK96) disable iff (RESET96)
        buf_wr_i.valid |-> buf_wr_i.x < 9'(SCREEN_W))
        else $error("line buffer write outside the visible width");

    wr_opaque: assert property (@(posedge CLK96) disable iff (RESET96)
        buf_wr_i.valid |-> buf_wr_i.pixel[3:0] != 4'h0)
        else $error("transparent pixel written to the line buffer");

endmodule

bind scroll_tile_render scroll_layer_chk scroll_layer_chk_inst (
    .CLK96     (CLK96),
    .RESET96   (RESET96),
    .gfx_cs_i  (gfx_cs_o),
    .gfx_req_i (gfx_req_o),
    .gfx_ok_i  (gfx_ok_i),
    .buf_wr_i  (buf_wr_o)
);

// ==== testbench/scroll_layer_tb.sv ====
// testbench for the scroll layer: video timing, tilemap and ROM models, reference model, pixel checks
`timescale 1ns/10ps

module scroll_layer_tb
    import scroll_pkg::*;
();

    localparam int NUM_LINES = 40;
    localparam int LINE_CLKS = 1024;   // 512 pixels of 2 clocks

    logic      CLK96;
    logic      RESET96;
    logic      pixel_cen_i;
    logic      active_i;
    logic      hblank_i;
    line_t     h_i;
    line_t     vrender_i;
    scroll_t   scroll_x_i;
    scroll_t   scroll_y_i;
    map_addr_t map_addr_o;
    map_word_t map_data_i;
    logic      gfx_cs_o;
    gfx_req_t  gfx_req_o;
    logic      gfx_ok_i;
    gfx_data_t gfx_data_i;
    pixel_t    pixel_o;

    integer    seed;
    logic [9:0] clk_cnt;
    logic [2:0] rom_wait;
    int        lines_done;
    int        ok_count;     // gfx_ok pulses seen in the current line
    int        pixel_checks;
    int        pixel_errors;
    int        count_errors;
    int        other_errors;
    int        timeout_errors;
    logic      chk_pend;
    line_t     chk_h;
    line_t     chk_line;

    map_word_t map_ram [2048];
    gfx_data_t rom_tab [8192];
    scroll_t   sx_hist [512];   // scroll values used by each line
    scroll_t   sy_hist [512];
    logic      blank_hist [512];
    logic      valid_hist [512];

    scroll_layer scroll_layer_inst (.*);

    always #50 CLK96 = ~CLK96;

    // ROM table slot, folds the whole tile number in
    function automatic logic [12:0] rom_index(input map_word_t num, input logic [3:0] row,
                                              input logic slice);
        return {num[7:0] ^ num[15:8], row, slice};
    endfunction

    // attribute word of scanned column k; tile number sits one word above
    function automatic logic [10:0] entry_base(input line_t line, input int k);
        int sx;
        int sy;
        int r;
        int c;
        sx = int'(sx_hist[line]);
        sy = int'(sy_hist[line]);
        r  = ((sy >>> 4) + ((int'(line) + (sy & 15)) >> 4)) & 31;
        c  = ((sx >>> 4) + k) & 31;
        return 11'(64 * r + 2 * c);
    endfunction

    function automatic pixel_t expected_pixel(input line_t line, input int x);
        int         pos;
        int         p;
        logic [10:0] base;
        map_word_t  attr;
        map_word_t  num;
        logic [3:0] row;
        gfx_data_t  data;
        logic [3:0] code;
        pos  = x + (int'(sx_hist[line]) & 15);
        p    = pos & 15;   // pixel inside the tile
        base = entry_base(line, pos >> 4);
        attr = map_ram[base];
        num  = map_ram[base | 11'd1];
        if (blank_hist[line] || num == 16'h0000) begin
            return '0;
        end
        row  = 4'((int'(line) + int'(sy_hist[line])) & 15);
        data = rom_tab[rom_index(num, row, p[3])];
        code = data[4 * (p & 7) +: 4];
        if (code == 4'h0) begin
            return '0;
        end
        return {attr[11:8], attr[6:0], code};
    endfunction

    function automatic int tile_count(input line_t line);
        int n;
        n = 0;
        for (int k = 0; k < MAP_COLS_SCANNED; k++) begin
            if (!blank_hist[line] && map_ram[entry_base(line, k) | 11'd1] != 16'h0000) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic fill_models();
        for (int i = 0; i < 2048; i++) begin
            if (i[0] && ($random(seed) & 3) == 0) begin
                map_ram[i] = '0;   // roughly a quarter of tiles blank
            end else begin
                map_ram[i] = 16'($random(seed));
            end
        end
        for (int i = 0; i < 8192; i++) begin
            for (int n = 0; n < 8; n++) begin
                if (($random(seed) & 3) == 0) begin
                    rom_tab[i][4 * n +: 4] = 4'h0;
                end else begin
                    rom_tab[i][4 * n +: 4] = 4'($random(seed));
                end
            end
        end
    endtask

    task automatic check_pixel(input line_t line, input line_t h);
        pixel_t exp;
        exp = expected_pixel(line, int'(h));
        pixel_checks++;
        assert (pixel_o == exp) else begin
            pixel_errors++;
            $display("[FAIL] pixel_o=%h expected %h h=%h line=%h", pixel_o, exp, h, line);
        end
    endtask

    task automatic check_idle_until_line();
        int t;
        t = 0;
        while (hblank_i && t < 2 * LINE_CLKS) begin
            @(posedge CLK96);
            assert (!gfx_cs_o && pixel_o == '0) else begin
                other_errors++;
                $display("[FAIL] gfx_cs_o=%h pixel_o=%h expected 0 before first line",
                         gfx_cs_o, pixel_o);
            end
            t++;
        end
        if (hblank_i) begin
            timeout_errors++;
            $display("timeout: hblank never fell after reset");
        end
    endtask

    task automatic wait_lines(input int n);
        int t;
        t = 0;
        while (lines_done < n && t < (n + 2) * LINE_CLKS) begin
            @(posedge CLK96);
            t++;
        end
        if (lines_done < n) begin
            timeout_errors++;
            $display("timeout: video timing stopped before the last line");
        end
    endtask

    // pixel_cen on the second clock of each pixel, after the bank has switched at h 0
    always @(posedge CLK96) begin
        logic [9:0] nxt;
        line_t      v;
        scroll_t    nsx;
        scroll_t    nsy;
        nxt = clk_cnt + 10'd1;
        clk_cnt     <= nxt;
        h_i         <= nxt[9:1];
        pixel_cen_i <= nxt[0];
        active_i    <= (nxt[9:1] < 9'(SCREEN_W));
        hblank_i    <= (nxt[9:1] >= 9'(SCREEN_W));
        if (gfx_ok_i) begin
            ok_count++;
        end
        if (nxt == 10'd0) begin
            if (valid_hist[vrender_i]) begin
                assert (ok_count == 2 * tile_count(vrender_i)) else begin
                    count_errors++;
                    $display("[FAIL] gfx_ok pulses=%h expected %h line=%h",
                             ok_count, 2 * tile_count(vrender_i), vrender_i);
                end
            end
            ok_count = 0;
            v = vrender_i + 9'd1;
            if (v[1:0] == 2'd0) begin
                nsx = scroll_t'($random(seed));   // new scroll every 4 lines
                nsy = scroll_t'($random(seed));
            end else begin
                nsx = scroll_x_i;
                nsy = scroll_y_i;
            end
            scroll_x_i    <= nsx;
            scroll_y_i    <= nsy;
            vrender_i     <= v;
            sx_hist[v]    = nsx;
            sy_hist[v]    = nsy;
            blank_hist[v] = (v[2:0] == 3'd5);
            // first line after reset lands on a bank never cleared
            valid_hist[v] = !RESET96 && lines_done > 0;
            if (!RESET96) begin
                lines_done <= lines_done + 1;
            end
        end
    end

    always @(posedge CLK96) begin
        if (map_addr_o[0] && blank_hist[vrender_i]) begin
            map_data_i <= '0;
        end else begin
            map_data_i <= map_ram[map_addr_o[10:0]];
        end
    end

    // ROM answers after a random wait
    always @(posedge CLK96) begin
        if (gfx_ok_i) begin
            gfx_ok_i <= 1'b0;
        end else if (gfx_cs_o) begin
            if (rom_wait == 3'd0) begin
                rom_wait <= 3'(1 + ($unsigned($random(seed)) % 6));
            end else if (rom_wait == 3'd1) begin
                rom_wait   <= 3'd0;
                gfx_ok_i   <= 1'b1;
                gfx_data_i <= rom_tab[rom_index({gfx_req_o.bank, gfx_req_o.code},
                                                gfx_req_o.row, gfx_req_o.slice)];
            end else begin
                rom_wait <= rom_wait - 3'd1;
            end
        end
    end

    // pixel_o of a read is checked half a clock later
    always @(posedge CLK96) begin
        chk_pend <= pixel_cen_i && active_i && !RESET96;
        chk_h    <= h_i;
        chk_line <= vrender_i - 9'd1;
    end

    always @(negedge CLK96) begin
        if (chk_pend && valid_hist[chk_line]) begin
            check_pixel(chk_line, chk_h);
        end
    end

    initial begin
        int total;
        seed           = 32'hb6f9021e;
        CLK96          = 1'b0;
        RESET96        = 1'b1;
        clk_cnt        = 10'd640;   // start inside hblank
        h_i            = 9'd320;
        pixel_cen_i    = 1'b0;
        active_i       = 1'b0;
        hblank_i       = 1'b1;
        vrender_i      = '0;
        map_data_i     = '0;
        gfx_ok_i       = 1'b0;
        gfx_data_i     = '0;
        rom_wait       = '0;
        chk_pend       = 1'b0;
        chk_h          = '0;
        chk_line       = '0;
        lines_done     = 0;
        ok_count       = 0;
        pixel_checks   = 0;
        pixel_errors   = 0;
        count_errors   = 0;
        other_errors   = 0;
        timeout_errors = 0;
        for (int i = 0; i < 512; i++) begin
            valid_hist[i] = 1'b0;
            blank_hist[i] = 1'b0;
        end
        fill_models();
        scroll_x_i = scroll_t'($random(seed));
        scroll_y_i = scroll_t'($random(seed));
        sx_hist[0] = scroll_x_i;
        sy_hist[0] = scroll_y_i;

        repeat (8) @(posedge CLK96);
        RESET96 <= 1'b0;
        check_idle_until_line();
        if (timeout_errors == 0) begin
            wait_lines(NUM_LINES);
        end

        if (pixel_checks == 0) begin
            other_errors++;
            $display("no pixel was compared against the model");
        end
        total = pixel_errors + count_errors + other_errors + timeout_errors;
        $display("errors: pixel %0d, fetch count %0d, other %0d, timeout %0d (%0d pixels checked)",
                 pixel_errors, count_errors, other_errors, timeout_errors, pixel_checks);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== scroll_layer.f ====
hw/scroll_pkg.sv
hw/scroll_tilemap_scan.sv
hw/scroll_priority_queue.sv
hw/scroll_tile_render.sv
hw/scroll_line_buffer.sv
hw/scroll_layer.sv
testbench/scroll_layer_chk.sv
testbench/scroll_layer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module scroll_layer_tb -f scroll_layer.f

status=0
./obj_dir/Vscroll_layer_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '>>> FAIL' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
